// ==== hw/rcfg_pkg.sv ====
// Reconfiguration bridge package with widths, CSR map, profile sizes and bus types
`default_nettype none

package rcfg_pkg;

  // Bus widths
  localparam int ADDR_BITS       = 10;
  localparam int DATA_WIDTH      = 32;
  localparam int XCVR_DATA_WIDTH = 8;

  // Soft CSR decode and register offsets
  localparam int CSR_SEL_BIT = 9;
  localparam logic [CSR_SEL_BIT-1:0] CSR_STATUS    = 'd0;
  localparam logic [CSR_SEL_BIT-1:0] CSR_PD_CTRL   = 'd1;
  localparam logic [CSR_SEL_BIT-1:0] CSR_STRM_CTRL = 'd2;

  // Embedded streamer profiles
  localparam int PROFILE_CNT      = 2;
  localparam int PROFILE_WORDS    = 4;
  localparam int PROFILE_SEL_BITS = 1;
  localparam int WORD_IDX_BITS    = 2;
  localparam logic [ADDR_BITS-1:0]       PROFILE_BASE_ADDR = 10'h010;
  localparam logic [XCVR_DATA_WIDTH-1:0] PROFILE_DATA_BASE = 8'hA0;

  // One AVMM request on the 8-bit channel
  typedef struct packed {
    logic                       write;
    logic                       read;
    logic [ADDR_BITS-1:0]       address;
    logic [XCVR_DATA_WIDTH-1:0] writedata;
  } avmm_req_t;

  // One profile entry
  typedef struct packed {
    logic [ADDR_BITS-1:0]       address;
    logic [XCVR_DATA_WIDTH-1:0] data;
  } rcfg_word_t;

  // Streamer control from the soft CSR
  typedef struct packed {
    logic [PROFILE_SEL_BITS-1:0] cfg_sel;
    logic                        cfg_load;
  } strm_ctrl_t;

endpackage

`default_nettype wire

// ==== hw/rcfg_strm_fsm.sv ====
// Streamer sequencer that walks one profile and writes each entry to the transceiver
`timescale 1ns/100ps
`default_nettype none

module rcfg_strm_fsm
  import rcfg_pkg::*;
(
  input  logic       reconfig_clk,
  input  logic       rst_n,
  input  strm_ctrl_t strm_ctrl,
  input  rcfg_word_t rom_word,
  input  logic       last_word,
  input  logic       strm_waitrequest,
  output avmm_req_t  strm_req,
  output logic       strm_busy,
  output logic       cnt_clear,
  output logic       cnt_incr
);

  typedef enum logic [1:0] {
    IDLE,
    WRITE,
    DONE
  } state_t;

  state_t state;
  state_t state_nxt;
  logic   word_accepted;

  always_ff @(posedge reconfig_clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign word_accepted = (state == WRITE) && !strm_waitrequest;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    if (strm_ctrl.cfg_load) state_nxt = WRITE;
      WRITE:   if (word_accepted && last_word) state_nxt = DONE;
      DONE:    state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  assign strm_busy = (state == WRITE);
  assign cnt_clear = (state == IDLE) && strm_ctrl.cfg_load;
  assign cnt_incr  = word_accepted;

  // Present the current ROM entry as a write for as long as the channel stalls it
  assign strm_req = '{write:     strm_busy,
                      read:      1'b0,
                      address:   rom_word.address,
                      writedata: rom_word.data};

  // A stalled write keeps its address and data until the channel takes it
  a_strm_hold: assert property (@(posedge reconfig_clk) disable iff (!rst_n)
    strm_req.write && strm_waitrequest |=> strm_req.write && $stable(strm_req));

endmodule

`default_nettype wire

// ==== hw/rcfg_strm_counter.sv ====
// Word index counter for the streamer with a flag on the final profile word
`timescale 1ns/100ps
`default_nettype none

module rcfg_strm_counter
  import rcfg_pkg::*;
(
  input  logic                     reconfig_clk,
  input  logic                     rst_n,
  input  logic                     cnt_clear,
  input  logic                     cnt_incr,
  output logic [WORD_IDX_BITS-1:0] word_idx,
  output logic                     last_word
);

  always_ff @(posedge reconfig_clk or negedge rst_n) begin
    if (!rst_n) begin
      word_idx <= '0;
    end else if (cnt_clear) begin
      word_idx <= '0;
    end else if (cnt_incr) begin
      word_idx <= word_idx + 1'b1;
    end
  end

  // Compare on the registered index so the flag is glitch free
  assign last_word = (word_idx == WORD_IDX_BITS'(PROFILE_WORDS - 1));

  // Clear only comes from IDLE and increment only from WRITE
  a_clear_incr_excl: assert property (@(posedge reconfig_clk) disable iff (!rst_n)
    !(cnt_clear && cnt_incr));

endmodule

`default_nettype wire

// ==== hw/rcfg_profile_rom.sv ====
// Constant table of address and data pairs for each streamer profile
`timescale 1ns/100ps
`default_nettype none

module rcfg_profile_rom
  import rcfg_pkg::*;
(
  input  logic [PROFILE_SEL_BITS-1:0] cfg_sel,
  input  logic [WORD_IDX_BITS-1:0]    word_idx,
  output rcfg_word_t                  rom_word
);

  rcfg_word_t profile_table [PROFILE_CNT][PROFILE_WORDS];

  // Entry p,i targets consecutive registers and carries a profile tagged byte
  function automatic rcfg_word_t make_entry(input int p, input int i);
    rcfg_word_t e;
    e.address = PROFILE_BASE_ADDR + ADDR_BITS'(i);
    e.data    = PROFILE_DATA_BASE + XCVR_DATA_WIDTH'(16 * p + i);
    return e;
  endfunction

  always_comb begin
    for (int p = 0; p < PROFILE_CNT; p++) begin
      for (int i = 0; i < PROFILE_WORDS; i++) begin
        profile_table[p][i] = make_entry(p, i);
      end
    end
  end

  assign rom_word = profile_table[cfg_sel][word_idx];

endmodule

`default_nettype wire

// ==== hw/rcfg_arbiter.sv ====
// Channel arbiter between the streamer and the user port, with 32 to 8 bit data narrowing
`timescale 1ns/100ps
`default_nettype none

module rcfg_arbiter
  import rcfg_pkg::*;
(
  input  logic                       user_write,
  input  logic                       user_read,
  input  logic [ADDR_BITS-1:0]       user_address,
  input  logic [DATA_WIDTH-1:0]      user_writedata,
  output logic                       user_waitrequest,
  output logic [DATA_WIDTH-1:0]      user_readdata,
  input  avmm_req_t                  strm_req,
  input  logic                       strm_busy,
  output logic                       strm_waitrequest,
  output avmm_req_t                  chnl_req,
  input  logic                       chnl_waitrequest,
  input  logic [XCVR_DATA_WIDTH-1:0] chnl_readdata
);

  avmm_req_t user_req;

  // The transceiver only takes the low byte of each user word
  assign user_req = '{write:     user_write,
                      read:      user_read,
                      address:   user_address,
                      writedata: user_writedata[XCVR_DATA_WIDTH-1:0]};

  // Streamer owns the channel for its whole run
  assign chnl_req = strm_busy ? strm_req : user_req;

  // User strobes are held off and not forwarded while streaming
  assign user_waitrequest = strm_busy ? 1'b1 : chnl_waitrequest;
  assign strm_waitrequest = strm_busy ? chnl_waitrequest : 1'b1;

  assign user_readdata = DATA_WIDTH'(chnl_readdata);

endmodule

`default_nettype wire

// ==== hw/pll_soft_csr.sv ====
// PLL soft CSR with status readback, powerdown override and streamer start control
`timescale 1ns/100ps
`default_nettype none

module pll_soft_csr
  import rcfg_pkg::*;
(
  input  logic                       reconfig_clk,
  input  logic                       rst_n,
  input  avmm_req_t                  chnl_req,
  output logic                       chnl_waitrequest,
  output logic [XCVR_DATA_WIDTH-1:0] chnl_readdata,
  output avmm_req_t                  xcvr_req,
  input  logic [XCVR_DATA_WIDTH-1:0] avmm_readdata,
  input  logic                       avmm_waitrequest,
  input  logic                       in_pll_powerdown,
  input  logic                       in_pll_locked,
  input  logic                       in_pll_cal_busy,
  input  logic                       in_avmm_busy,
  output strm_ctrl_t                 strm_ctrl,
  output logic                       out_pll_powerdown
);

  logic                        csr_sel;
  logic                        csr_wr;
  logic [CSR_SEL_BIT-1:0]      csr_offset;
  logic [XCVR_DATA_WIDTH-1:0]  csr_rdata;
  logic                        pd_ovr_en;
  logic                        pd_ovr_val;
  logic [PROFILE_SEL_BITS-1:0] cfg_sel_q;
  logic                        load_q;

  assign csr_sel    = chnl_req.address[CSR_SEL_BIT];
  assign csr_offset = chnl_req.address[CSR_SEL_BIT-1:0];

  // The load cycle stalls the channel until the streamer raises busy
  assign csr_wr = chnl_req.write && csr_sel && !load_q;

  always_ff @(posedge reconfig_clk or negedge rst_n) begin
    if (!rst_n) begin
      pd_ovr_en  <= 1'b0;
      pd_ovr_val <= 1'b0;
      cfg_sel_q  <= '0;
      load_q     <= 1'b0;
    end else begin
      load_q <= csr_wr && (csr_offset == CSR_STRM_CTRL) && chnl_req.writedata[7];
      if (csr_wr && (csr_offset == CSR_PD_CTRL)) begin
        pd_ovr_en  <= chnl_req.writedata[0];
        pd_ovr_val <= chnl_req.writedata[1];
      end
      if (csr_wr && (csr_offset == CSR_STRM_CTRL)) begin
        cfg_sel_q <= chnl_req.writedata[PROFILE_SEL_BITS-1:0];
      end
    end
  end

  always_comb begin
    case (csr_offset)
      CSR_STATUS:    csr_rdata = {4'b0, in_pll_powerdown, in_avmm_busy,
                                  in_pll_cal_busy, in_pll_locked};
      CSR_PD_CTRL:   csr_rdata = {6'b0, pd_ovr_val, pd_ovr_en};
      CSR_STRM_CTRL: csr_rdata = XCVR_DATA_WIDTH'(cfg_sel_q);
      default:       csr_rdata = '0;
    endcase
  end

  // Split the channel between the soft registers and the transceiver
  assign xcvr_req = '{write:     chnl_req.write && !csr_sel && !load_q,
                      read:      chnl_req.read && !csr_sel && !load_q,
                      address:   chnl_req.address,
                      writedata: chnl_req.writedata};

  assign chnl_waitrequest = load_q || (!csr_sel && avmm_waitrequest);
  assign chnl_readdata    = csr_sel ? csr_rdata : avmm_readdata;

  assign strm_ctrl         = '{cfg_sel: cfg_sel_q, cfg_load: load_q};
  assign out_pll_powerdown = pd_ovr_en ? pd_ovr_val : in_pll_powerdown;

endmodule

`default_nettype wire

// ==== hw/atx_pll_rcfg_top.sv ====
// ATX PLL reconfiguration bridge top with user port, soft CSR and embedded streamer
`timescale 1ns/100ps
`default_nettype none

module atx_pll_rcfg_top
  import rcfg_pkg::*;
(
  input  logic                       reconfig_clk,
  input  logic                       rst_n,
  // User reconfiguration port
  input  logic                       reconfig_write,
  input  logic                       reconfig_read,
  input  logic [ADDR_BITS-1:0]       reconfig_address,
  input  logic [DATA_WIDTH-1:0]      reconfig_writedata,
  output logic [DATA_WIDTH-1:0]      reconfig_readdata,
  output logic                       reconfig_waitrequest,
  // Transceiver AVMM port
  output logic                       avmm_write,
  output logic                       avmm_read,
  output logic [ADDR_BITS-1:0]       avmm_address,
  output logic [XCVR_DATA_WIDTH-1:0] avmm_writedata,
  input  logic [XCVR_DATA_WIDTH-1:0] avmm_readdata,
  input  logic                       avmm_waitrequest,
  // PLL status and control
  input  logic                       in_pll_powerdown,
  input  logic                       in_pll_locked,
  input  logic                       in_pll_cal_busy,
  input  logic                       in_avmm_busy,
  output logic                       out_pll_powerdown
);

  avmm_req_t                  strm_req;
  avmm_req_t                  chnl_req;
  avmm_req_t                  xcvr_req;
  strm_ctrl_t                 strm_ctrl;
  rcfg_word_t                 rom_word;
  logic                       strm_busy;
  logic                       strm_waitrequest;
  logic                       chnl_waitrequest;
  logic [XCVR_DATA_WIDTH-1:0] chnl_readdata;
  logic                       cnt_clear;
  logic                       cnt_incr;
  logic [WORD_IDX_BITS-1:0]   word_idx;
  logic                       last_word;

  rcfg_strm_fsm i_strm_fsm (
    .reconfig_clk     (reconfig_clk),
    .rst_n            (rst_n),
    .strm_ctrl        (strm_ctrl),
    .rom_word         (rom_word),
    .last_word        (last_word),
    .strm_waitrequest (strm_waitrequest),
    .strm_req         (strm_req),
    .strm_busy        (strm_busy),
    .cnt_clear        (cnt_clear),
    .cnt_incr         (cnt_incr)
  );

  rcfg_strm_counter i_strm_counter (
    .reconfig_clk (reconfig_clk),
    .rst_n        (rst_n),
    .cnt_clear    (cnt_clear),
    .cnt_incr     (cnt_incr),
    .word_idx     (word_idx),
    .last_word    (last_word)
  );

  // Profile select is the CSR register, which cannot change while the user is stalled
  rcfg_profile_rom i_profile_rom (
    .cfg_sel  (strm_ctrl.cfg_sel),
    .word_idx (word_idx),
    .rom_word (rom_word)
  );

  rcfg_arbiter i_arbiter (
    .user_write       (reconfig_write),
    .user_read        (reconfig_read),
    .user_address     (reconfig_address),
    .user_writedata   (reconfig_writedata),
    .user_waitrequest (reconfig_waitrequest),
    .user_readdata    (reconfig_readdata),
    .strm_req         (strm_req),
    .strm_busy        (strm_busy),
    .strm_waitrequest (strm_waitrequest),
    .chnl_req         (chnl_req),
    .chnl_waitrequest (chnl_waitrequest),
    .chnl_readdata    (chnl_readdata)
  );

  pll_soft_csr i_soft_csr (
    .reconfig_clk      (reconfig_clk),
    .rst_n             (rst_n),
    .chnl_req          (chnl_req),
    .chnl_waitrequest  (chnl_waitrequest),
    .chnl_readdata     (chnl_readdata),
    .xcvr_req          (xcvr_req),
    .avmm_readdata     (avmm_readdata),
    .avmm_waitrequest  (avmm_waitrequest),
    .in_pll_powerdown  (in_pll_powerdown),
    .in_pll_locked     (in_pll_locked),
    .in_pll_cal_busy   (in_pll_cal_busy),
    .in_avmm_busy      (in_avmm_busy),
    .strm_ctrl         (strm_ctrl),
    .out_pll_powerdown (out_pll_powerdown)
  );

  assign avmm_write     = xcvr_req.write;
  assign avmm_read      = xcvr_req.read;
  assign avmm_address   = xcvr_req.address;
  assign avmm_writedata = xcvr_req.writedata;

endmodule

`default_nettype wire

// ==== bench/xcvr_avmm_model.sv ====
// Transceiver AVMM register model with byte storage and random back-pressure
`timescale 1ns/100ps
`default_nettype none

module xcvr_avmm_model
  import rcfg_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       avmm_write,
  input  logic                       avmm_read,
  input  logic [ADDR_BITS-1:0]       avmm_address,
  input  logic [XCVR_DATA_WIDTH-1:0] avmm_writedata,
  output logic [XCVR_DATA_WIDTH-1:0] avmm_readdata,
  output logic                       avmm_waitrequest,
  output logic [31:0]                write_count
);

  logic [XCVR_DATA_WIDTH-1:0] mem [1 << ADDR_BITS];
  integer                     seed;

  // Power-up contents mix both address bytes
  initial begin
    seed = 32'h9bbe;
    for (int a = 0; a < (1 << ADDR_BITS); a++) begin
      mem[a] = XCVR_DATA_WIDTH'(a) ^ XCVR_DATA_WIDTH'(a >> 8);
    end
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      avmm_waitrequest <= 1'b1;
      write_count      <= '0;
    end else begin
      // Stall roughly one cycle in four
      avmm_waitrequest <= (($random(seed) & 3) == 0);
      if (avmm_write && !avmm_waitrequest) begin
        mem[avmm_address] <= avmm_writedata;
        write_count       <= write_count + 32'd1;
      end
    end
  end

  // Read data is only driven while a read is presented
  assign avmm_readdata = avmm_read ? mem[avmm_address] : '0;

endmodule

`default_nettype wire

// ==== bench/tb_atx_pll_rcfg.sv ====
// Testbench for the ATX PLL reconfiguration bridge with user, CSR and streamer checks
`timescale 1ns/100ps
`default_nettype none

module tb_atx_pll_rcfg
  import rcfg_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 200;

  logic                       clk;
  logic                       rst_n;
  logic                       reconfig_write;
  logic                       reconfig_read;
  logic [ADDR_BITS-1:0]       reconfig_address;
  logic [DATA_WIDTH-1:0]      reconfig_writedata;
  logic [DATA_WIDTH-1:0]      reconfig_readdata;
  logic                       reconfig_waitrequest;
  logic                       avmm_write;
  logic                       avmm_read;
  logic [ADDR_BITS-1:0]       avmm_address;
  logic [XCVR_DATA_WIDTH-1:0] avmm_writedata;
  logic [XCVR_DATA_WIDTH-1:0] avmm_readdata;
  logic                       avmm_waitrequest;
  logic                       in_pll_powerdown;
  logic                       in_pll_locked;
  logic                       in_pll_cal_busy;
  logic                       in_avmm_busy;
  logic                       out_pll_powerdown;
  logic [31:0]                model_write_count;
  logic [31:0]                strm_count_base;
  logic                       arrival_check;
  integer                     seed;

  atx_pll_rcfg_top i_dut (
    .reconfig_clk         (clk),
    .rst_n                (rst_n),
    .reconfig_write       (reconfig_write),
    .reconfig_read        (reconfig_read),
    .reconfig_address     (reconfig_address),
    .reconfig_writedata   (reconfig_writedata),
    .reconfig_readdata    (reconfig_readdata),
    .reconfig_waitrequest (reconfig_waitrequest),
    .avmm_write           (avmm_write),
    .avmm_read            (avmm_read),
    .avmm_address         (avmm_address),
    .avmm_writedata       (avmm_writedata),
    .avmm_readdata        (avmm_readdata),
    .avmm_waitrequest     (avmm_waitrequest),
    .in_pll_powerdown     (in_pll_powerdown),
    .in_pll_locked        (in_pll_locked),
    .in_pll_cal_busy      (in_pll_cal_busy),
    .in_avmm_busy         (in_avmm_busy),
    .out_pll_powerdown    (out_pll_powerdown)
  );

  xcvr_avmm_model i_model (
    .clk              (clk),
    .rst_n            (rst_n),
    .avmm_write       (avmm_write),
    .avmm_read        (avmm_read),
    .avmm_address     (avmm_address),
    .avmm_writedata   (avmm_writedata),
    .avmm_readdata    (avmm_readdata),
    .avmm_waitrequest (avmm_waitrequest),
    .write_count      (model_write_count)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      fail_run($sformatf("MISMATCH at %0t: %s expected %h actual %h",
                         $time, name, expected, actual));
    end
  endtask

  function automatic logic [ADDR_BITS-1:0] csr_addr(input logic [CSR_SEL_BIT-1:0] offset);
    return {1'b1, offset};
  endfunction

  // Bit order matches the status register layout
  task automatic set_pll_inputs(input logic [3:0] bits);
    @(posedge clk);
    #2;
    in_pll_locked    = bits[0];
    in_pll_cal_busy  = bits[1];
    in_avmm_busy     = bits[2];
    in_pll_powerdown = bits[3];
  endtask

  task automatic user_write(input logic [ADDR_BITS-1:0] addr, input logic [31:0] data);
    int cycles;
    cycles = 0;
    @(posedge clk);
    #2;
    reconfig_write     = 1'b1;
    reconfig_address   = addr;
    reconfig_writedata = data;
    @(negedge clk);
    while (reconfig_waitrequest) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        fail_run($sformatf("User write to address %h never completed", addr));
      end
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    reconfig_write = 1'b0;
  endtask

  task automatic user_read(input logic [ADDR_BITS-1:0] addr, output logic [31:0] data);
    int cycles;
    cycles = 0;
    @(posedge clk);
    #2;
    reconfig_read    = 1'b1;
    reconfig_address = addr;
    @(negedge clk);
    while (reconfig_waitrequest) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        fail_run($sformatf("User read from address %h never completed", addr));
      end
      @(negedge clk);
    end
    data = reconfig_readdata;
    @(posedge clk);
    #2;
    reconfig_read = 1'b0;
  endtask

  task automatic check_user_path(input logic [ADDR_BITS-1:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    user_write(addr, data);
    user_read(addr, rdata);
    check_value("reconfig_readdata", {24'b0, data[7:0]}, rdata);
  endtask

  task automatic check_status(input int rounds);
    logic [3:0]  pattern;
    logic [31:0] rdata;
    for (int k = 0; k < rounds; k++) begin
      pattern = 4'($random(seed));
      set_pll_inputs(pattern);
      user_read(csr_addr(CSR_STATUS), rdata);
      check_value("csr status", {28'b0, pattern}, rdata);
    end
  endtask

  task automatic check_override(input logic [1:0] ctrl, input logic pd_in,
                                input logic pd_expected);
    logic [31:0] rdata;
    user_write(csr_addr(CSR_PD_CTRL), {30'b0, ctrl});
    set_pll_inputs({pd_in, 3'b001});
    @(negedge clk);
    check_value("out_pll_powerdown", {31'b0, pd_expected},
                {31'b0, out_pll_powerdown});
    user_read(csr_addr(CSR_PD_CTRL), rdata);
    check_value("csr pd_ctrl", {30'b0, ctrl}, rdata);
  endtask

  // Load a profile, then issue a user read that must wait for the whole run
  task automatic check_profile(input int p);
    logic [31:0]          rdata;
    logic [ADDR_BITS-1:0] addr;
    strm_count_base = model_write_count;
    user_write(csr_addr(CSR_STRM_CTRL), 32'h80 | 32'(p));
    arrival_check = 1'b1;
    user_read(10'h055, rdata);
    arrival_check = 1'b0;
    for (int i = 0; i < PROFILE_WORDS; i++) begin
      addr = PROFILE_BASE_ADDR + ADDR_BITS'(i);
      check_value($sformatf("model mem[%h]", addr),
                  {24'b0, PROFILE_DATA_BASE} + 32'(16 * p + i),
                  {24'b0, i_model.mem[addr]});
    end
  endtask

  a_no_csr_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    (avmm_write || avmm_read) |-> !avmm_address[CSR_SEL_BIT])
    else fail_run($sformatf("MISMATCH at %0t: avmm_address[%0d] expected 0 actual 1",
                            $time, CSR_SEL_BIT));

  a_user_after_stream: assert property (@(posedge clk) disable iff (!rst_n)
    (arrival_check && avmm_read) |-> (model_write_count - strm_count_base == PROFILE_WORDS))
    else fail_run($sformatf("MISMATCH at %0t: streamer writes expected %0d actual %0d",
                            $time, PROFILE_WORDS, model_write_count - strm_count_base));

  initial begin
    seed               = 32'h9bbe;
    rst_n              = 1'b0;
    reconfig_write     = 1'b0;
    reconfig_read      = 1'b0;
    reconfig_address   = '0;
    reconfig_writedata = '0;
    in_pll_powerdown   = 1'b1;
    in_pll_locked      = 1'b0;
    in_pll_cal_busy    = 1'b0;
    in_avmm_busy       = 1'b0;
    strm_count_base    = '0;
    arrival_check      = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("avmm strobes", 32'd0, {30'b0, avmm_write, avmm_read});
    check_value("out_pll_powerdown", 32'd1, {31'b0, out_pll_powerdown});
    check_user_path(10'h123, 32'hdeadbe5a);
    check_user_path(10'h07f, 32'h12345681);
    check_status(8);
    check_override(2'b00, 1'b0, 1'b0);
    check_override(2'b11, 1'b0, 1'b1);
    check_override(2'b01, 1'b1, 1'b0);
    check_override(2'b00, 1'b1, 1'b1);
    check_profile(0);
    check_profile(1);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== atx_pll_rcfg_top.f ====
hw/rcfg_pkg.sv
hw/rcfg_strm_fsm.sv
hw/rcfg_strm_counter.sv
hw/rcfg_profile_rom.sv
hw/rcfg_arbiter.sv
hw/pll_soft_csr.sv
hw/atx_pll_rcfg_top.sv
bench/xcvr_avmm_model.sv
bench/tb_atx_pll_rcfg.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_atx_pll_rcfg
FILELIST = atx_pll_rcfg_top.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
